// ==== hdl/aw_queue_pkg.sv ====
// Queue entry struct, pointer type, depth constants and the
// gray code conversion functions shared by both clock domains
package aw_queue_pkg;

    // Number of entries in the register file and its address width
    localparam int unsigned AW_DEPTH  = 16;
    localparam int unsigned AW_ADDR_W = 4;

    // One extra bit above the address serves as the wrap flag
    localparam int unsigned AW_PTR_W  = AW_ADDR_W + 1;

    // Word stored in each register file entry (39 bits in total)
    typedef struct packed {
        logic [6:0]  qid;
        logic [31:0] data;
    } aw_entry_t;

    typedef logic [AW_PTR_W-1:0] aw_ptr_t;

    // Binary to gray conversion so that only one bit changes per increment
    function automatic aw_ptr_t bin2gray(input aw_ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    // Gray to binary conversion walks down from the top bit
    function automatic aw_ptr_t gray2bin(input aw_ptr_t gray);
        aw_ptr_t bin;
        bin[AW_PTR_W-1] = gray[AW_PTR_W-1];
        for (int i = AW_PTR_W - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

endpackage

// ==== hdl/mem_reset_sync.sv ====
// Reset synchronizer that produces a reset ending cleanly on one clock
`timescale 1ns/100ps

module mem_reset_sync #(
    parameter int unsigned SYNC_STAGES = 2
) (
    input  logic clk,
    input  logic rst_n,
    output logic rst_n_sync
);

    // Shift chain of flops that fills with ones once reset is released
    logic [SYNC_STAGES-1:0] sync_q;

    // The whole chain clears on the first edge that sees rst_n low
    // and then takes SYNC_STAGES edges to release the output
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], 1'b1};
        end
    end

    // The last stage drives the local reset of the domain
    assign rst_n_sync = sync_q[SYNC_STAGES-1];

endmodule

// ==== hdl/mem_rf_16x39.sv ====
// Two-port register file with a write port on wclk and a
// registered read port on rclk
`timescale 1ns/100ps

module mem_rf_16x39 (
    // Write port
    input  logic                                   wclk,
    input  logic                                   we,
    input  logic [aw_queue_pkg::AW_ADDR_W-1:0]     waddr,
    input  aw_queue_pkg::aw_entry_t                wdata,

    // Read port
    input  logic                                   rclk,
    input  logic                                   rclk_rst_n,
    input  logic                                   re,
    input  logic [aw_queue_pkg::AW_ADDR_W-1:0]     raddr,
    output aw_queue_pkg::aw_entry_t                rdata
);

    // Behavioural storage array standing in for the macro
    aw_queue_pkg::aw_entry_t mem [aw_queue_pkg::AW_DEPTH];

    // ------------------------------
    // Write side
    // ------------------------------

    // One entry is written per wclk edge with we high
    always_ff @(posedge wclk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // ------------------------------
    // Read side
    // ------------------------------

    // The addressed entry is registered on rclk and held between reads
    // The output register clears to zero under the read domain reset
    always_ff @(posedge rclk) begin
        if (!rclk_rst_n) begin
            rdata <= '0;
        end else if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

// ==== hdl/aw_push_ctl.sv ====
// Write side controller with the push handshake, the write pointers,
// the read pointer synchronizer and the full test
`timescale 1ns/100ps

module aw_push_ctl #(
    parameter int unsigned SYNC_STAGES = 2
) (
    input  logic                                   wclk,
    input  logic                                   wrst_n,

    // Producer handshake
    input  logic                                   push_req,
    input  aw_queue_pkg::aw_entry_t                push_entry,
    output logic                                   push_ack,

    // Pointers crossing between the domains
    input  aw_queue_pkg::aw_ptr_t                  rd_ptr_gray,
    output aw_queue_pkg::aw_ptr_t                  wr_ptr_gray,

    // Register file write port
    output logic                                   we,
    output logic [aw_queue_pkg::AW_ADDR_W-1:0]     waddr,
    output aw_queue_pkg::aw_entry_t                wdata
);

    aw_queue_pkg::aw_ptr_t wr_bin_q;
    aw_queue_pkg::aw_ptr_t wr_gray_q;
    aw_queue_pkg::aw_ptr_t wr_bin_nxt;
    aw_queue_pkg::aw_ptr_t rd_sync_q [SYNC_STAGES];
    aw_queue_pkg::aw_ptr_t rd_bin_sync;
    logic                  full;
    logic                  push_accept;

    // ------------------------------
    // Read pointer synchronizer
    // ------------------------------

    // The gray pointer changes one bit at a time so the flop chain
    // only ever lands on the old or the new value
    always_ff @(posedge wclk) begin
        if (!wrst_n) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                rd_sync_q[i] <= '0;
            end
        end else begin
            rd_sync_q[0] <= rd_ptr_gray;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                rd_sync_q[i] <= rd_sync_q[i-1];
            end
        end
    end

    assign rd_bin_sync = aw_queue_pkg::gray2bin(rd_sync_q[SYNC_STAGES-1]);

    // Full when the wrap bits differ and the addresses match
    // The synchronized read pointer lags so this errs towards full
    assign full = (wr_bin_q[aw_queue_pkg::AW_ADDR_W] != rd_bin_sync[aw_queue_pkg::AW_ADDR_W]) &&
                  (wr_bin_q[aw_queue_pkg::AW_ADDR_W-1:0] ==
                   rd_bin_sync[aw_queue_pkg::AW_ADDR_W-1:0]);

    // ------------------------------
    // Push handshake
    // ------------------------------

    // Ack only falls once req has been seen low, so a low ack means
    // the last handshake has closed and a new request may be taken
    assign push_accept = push_req && !push_ack && !full;
    assign wr_bin_nxt  = wr_bin_q + 1'b1;

    always_ff @(posedge wclk) begin
        if (!wrst_n) begin
            push_ack  <= 1'b0;
            wr_bin_q  <= '0;
            wr_gray_q <= '0;
        end else begin
            if (push_accept) begin
                // The entry is written on this edge and ack rises with it
                push_ack  <= 1'b1;
                wr_bin_q  <= wr_bin_nxt;
                wr_gray_q <= aw_queue_pkg::bin2gray(wr_bin_nxt);
            end else if (!push_req) begin
                // Producer has dropped req so the handshake closes
                push_ack <= 1'b0;
            end
        end
    end

    // Write port follows the accepted push directly
    assign we          = push_accept;
    assign waddr       = wr_bin_q[aw_queue_pkg::AW_ADDR_W-1:0];
    assign wdata       = push_entry;
    assign wr_ptr_gray = wr_gray_q;

endmodule

// ==== hdl/aw_pop_ctl.sv ====
// Read side controller with the pop handshake, the read pointers,
// the write pointer synchronizer, the empty test and data capture
`timescale 1ns/100ps

module aw_pop_ctl #(
    parameter int unsigned SYNC_STAGES = 2
) (
    input  logic                                   rclk,
    input  logic                                   rrst_n,

    // Consumer handshake
    input  logic                                   pop_req,
    output logic                                   pop_ack,
    output aw_queue_pkg::aw_entry_t                pop_entry,

    // Pointers crossing between the domains
    input  aw_queue_pkg::aw_ptr_t                  wr_ptr_gray,
    output aw_queue_pkg::aw_ptr_t                  rd_ptr_gray,

    // Register file read port
    output logic                                   re,
    output logic [aw_queue_pkg::AW_ADDR_W-1:0]     raddr,
    input  aw_queue_pkg::aw_entry_t                rdata
);

    // Read sequence states
    // RD_ISSUE waits for a request and issues the read
    // RD_CAPTURE takes the registered data one edge later
    typedef enum logic {
        RD_ISSUE,
        RD_CAPTURE
    } rd_state_t;

    rd_state_t             state_q;
    aw_queue_pkg::aw_ptr_t rd_bin_q;
    aw_queue_pkg::aw_ptr_t rd_gray_q;
    aw_queue_pkg::aw_ptr_t rd_bin_nxt;
    aw_queue_pkg::aw_ptr_t wr_sync_q [SYNC_STAGES];
    logic                  empty;
    logic                  pop_issue;

    // ------------------------------
    // Write pointer synchronizer
    // ------------------------------

    always_ff @(posedge rclk) begin
        if (!rrst_n) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                wr_sync_q[i] <= '0;
            end
        end else begin
            wr_sync_q[0] <= wr_ptr_gray;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                wr_sync_q[i] <= wr_sync_q[i-1];
            end
        end
    end

    // Empty when both gray pointers match in every bit including wrap
    // A late write pointer only makes the queue look empty for longer
    assign empty = (rd_gray_q == wr_sync_q[SYNC_STAGES-1]);

    // ------------------------------
    // Pop sequence
    // ------------------------------

    // A new read starts only when the previous handshake has closed
    assign pop_issue  = pop_req && !pop_ack && !empty && (state_q == RD_ISSUE);
    assign rd_bin_nxt = rd_bin_q + 1'b1;

    always_ff @(posedge rclk) begin
        if (!rrst_n) begin
            state_q   <= RD_ISSUE;
            pop_ack   <= 1'b0;
            rd_bin_q  <= '0;
            rd_gray_q <= '0;
        end else begin
            case (state_q)
                RD_ISSUE: begin
                    if (pop_issue) begin
                        // Register file latches the entry on this same edge
                        state_q   <= RD_CAPTURE;
                        rd_bin_q  <= rd_bin_nxt;
                        rd_gray_q <= aw_queue_pkg::bin2gray(rd_bin_nxt);
                    end else if (!pop_req) begin
                        pop_ack <= 1'b0;
                    end
                end
                RD_CAPTURE: begin
                    // Data is presented to the consumer with ack
                    state_q <= RD_ISSUE;
                    pop_ack <= 1'b1;
                end
                default: begin
                    state_q <= RD_ISSUE;
                end
            endcase
        end
    end

    // Entry is loaded only in the capture state when ack is still low
    // so it holds steady for as long as ack stays high
    always_ff @(posedge rclk) begin
        if (state_q == RD_CAPTURE) begin
            pop_entry <= rdata;
        end
    end

    assign re          = pop_issue;
    assign raddr       = rd_bin_q[aw_queue_pkg::AW_ADDR_W-1:0];
    assign rd_ptr_gray = rd_gray_q;

endmodule

// ==== hdl/aw_queue_top.sv ====
// Queue top level joining the reset synchronizers, the push and pop
// controllers and the register file
`timescale 1ns/100ps

module aw_queue_top #(
    parameter int unsigned SYNC_STAGES = 2
) (
    input  logic                    wclk,
    input  logic                    rclk,
    input  logic                    rst_n,

    // Producer side in the wclk domain
    input  logic                    push_req,
    input  aw_queue_pkg::aw_entry_t push_entry,
    output logic                    push_ack,

    // Consumer side in the rclk domain
    input  logic                    pop_req,
    output logic                    pop_ack,
    output aw_queue_pkg::aw_entry_t pop_entry
);

    // Local resets of the two domains
    logic                                   wrst_n;
    logic                                   rrst_n;

    // Gray pointers crossing between the domains
    aw_queue_pkg::aw_ptr_t                  wr_ptr_gray;
    aw_queue_pkg::aw_ptr_t                  rd_ptr_gray;

    // Register file ports
    logic                                   we;
    logic [aw_queue_pkg::AW_ADDR_W-1:0]     waddr;
    aw_queue_pkg::aw_entry_t                wdata;
    logic                                   re;
    logic [aw_queue_pkg::AW_ADDR_W-1:0]     raddr;
    aw_queue_pkg::aw_entry_t                rdata;

    // ------------------------------
    // Reset synchronizers
    // ------------------------------

    mem_reset_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) i_wrst_sync (
        .clk        (wclk),
        .rst_n      (rst_n),
        .rst_n_sync (wrst_n)
    );

    mem_reset_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) i_rrst_sync (
        .clk        (rclk),
        .rst_n      (rst_n),
        .rst_n_sync (rrst_n)
    );

    // ------------------------------
    // Controllers and storage
    // ------------------------------

    aw_push_ctl #(
        .SYNC_STAGES (SYNC_STAGES)
    ) i_push_ctl (
        .wclk        (wclk),
        .wrst_n      (wrst_n),
        .push_req    (push_req),
        .push_entry  (push_entry),
        .push_ack    (push_ack),
        .rd_ptr_gray (rd_ptr_gray),
        .wr_ptr_gray (wr_ptr_gray),
        .we          (we),
        .waddr       (waddr),
        .wdata       (wdata)
    );

    aw_pop_ctl #(
        .SYNC_STAGES (SYNC_STAGES)
    ) i_pop_ctl (
        .rclk        (rclk),
        .rrst_n      (rrst_n),
        .pop_req     (pop_req),
        .pop_ack     (pop_ack),
        .pop_entry   (pop_entry),
        .wr_ptr_gray (wr_ptr_gray),
        .rd_ptr_gray (rd_ptr_gray),
        .re          (re),
        .raddr       (raddr),
        .rdata       (rdata)
    );

    // Read output register is cleared by the read domain reset
    mem_rf_16x39 i_rf (
        .wclk       (wclk),
        .we         (we),
        .waddr      (waddr),
        .wdata      (wdata),
        .rclk       (rclk),
        .rclk_rst_n (rrst_n),
        .re         (re),
        .raddr      (raddr),
        .rdata      (rdata)
    );

endmodule

// ==== tb/aw_queue_assert.sv ====
// Concurrent handshake assertions for the queue top level
// and the bind that attaches them to it
`timescale 1ns/100ps

module aw_queue_assert (
    input logic                    wclk,
    input logic                    rclk,
    input logic                    wrst_n,
    input logic                    rrst_n,
    input logic                    push_req,
    input logic                    push_ack,
    input logic                    pop_req,
    input logic                    pop_ack,
    input aw_queue_pkg::aw_entry_t pop_entry
);

    // Number of assertion failures, read by the testbench at the end
    int unsigned fail_count = 0;

    // ------------------------------
    // Push side
    // ------------------------------

    // An ack may only answer a request that is present
    ack_rise_needs_req: assert property (@(posedge wclk) disable iff (!wrst_n)
        $rose(push_ack) |-> $past(push_req))
    else begin
        fail_count++;
        $error("push_ack rose without push_req");
    end

    // The ack is held for as long as the producer holds its request
    ack_held_with_req: assert property (@(posedge wclk) disable iff (!wrst_n)
        (push_ack && push_req) |=> push_ack)
    else begin
        fail_count++;
        $error("push_ack dropped while push_req was still high");
    end

    // ------------------------------
    // Pop side
    // ------------------------------

    // Data must not move under a raised ack
    entry_stable_with_ack: assert property (@(posedge rclk) disable iff (!rrst_n)
        pop_ack |=> (!pop_ack || $stable(pop_entry)))
    else begin
        fail_count++;
        $error("pop_entry changed while pop_ack was high");
    end

    // The ack only closes after the consumer has let go of its request
    ack_falls_after_req: assert property (@(posedge rclk) disable iff (!rrst_n)
        $fell(pop_ack) |-> !$past(pop_req))
    else begin
        fail_count++;
        $error("pop_ack fell while pop_req was still high");
    end

endmodule

bind aw_queue_top aw_queue_assert aw_queue_assert_inst (
    .wclk      (wclk),
    .rclk      (rclk),
    .wrst_n    (wrst_n),
    .rrst_n    (rrst_n),
    .push_req  (push_req),
    .push_ack  (push_ack),
    .pop_req   (pop_req),
    .pop_ack   (pop_ack),
    .pop_entry (pop_entry)
);

// ==== tb/aw_queue_tb.sv ====
// Directed testbench for the queue with clocks, reset, an LFSR,
// a scoreboard queue, a compare task and a cycle timeout
`timescale 1ns/100ps

module aw_queue_tb;

    // Galois taps for x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_MASK = 32'h8020_0003;

    // The slowest tests need roughly 1500 wclk cycles together,
    // the limit leaves more than twice that as margin
    localparam int unsigned TIMEOUT_CYCLES = 4000;

    logic                    wclk;
    logic                    rclk;
    logic                    rst_n;
    logic                    push_req;
    aw_queue_pkg::aw_entry_t push_entry;
    logic                    push_ack;
    logic                    pop_req;
    logic                    pop_ack;
    aw_queue_pkg::aw_entry_t pop_entry;

    logic [31:0]             lfsr_q;
    int unsigned             cycle_count;

    // Entries pushed but not yet popped, oldest at the front
    aw_queue_pkg::aw_entry_t sb_q [$];

    aw_queue_top #(
        .SYNC_STAGES (2)
    ) aw_queue_top_inst (
        .wclk       (wclk),
        .rclk       (rclk),
        .rst_n      (rst_n),
        .push_req   (push_req),
        .push_entry (push_entry),
        .push_ack   (push_ack),
        .pop_req    (pop_req),
        .pop_ack    (pop_ack),
        .pop_entry  (pop_entry)
    );

    // ------------------------------
    // Clocks and timeout
    // ------------------------------

    initial begin
        wclk = 1'b0;
        forever #5 wclk = ~wclk;
    end

    // The read clock runs at the same rate with a 3 ns offset
    initial begin
        rclk = 1'b0;
        #3;
        forever #5 rclk = ~rclk;
    end

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge wclk);
            cycle_count++;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                $display("Timeout: the tests did not finish in %0d wclk cycles",
                         TIMEOUT_CYCLES);
                $display("Done: errors found");
                $fatal(1, "Simulation stopped by the timeout");
            end
        end
    end

    // ------------------------------
    // Helpers
    // ------------------------------

    // Steps the LFSR once per bit and shifts each output bit in
    function automatic logic [63:0] take_bits(input int unsigned count);
        logic [63:0] bits;
        logic        out_bit;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            out_bit = lfsr_q[0];
            lfsr_q  = (lfsr_q >> 1) ^ (out_bit ? LFSR_MASK : 32'h0);
            bits    = {bits[62:0], out_bit};
        end
        return bits;
    endfunction

    function automatic aw_queue_pkg::aw_entry_t random_entry();
        logic [63:0] bits;
        bits = take_bits(39);
        return bits[38:0];
    endfunction

    task automatic check_task(input logic [63:0] got, input logic [63:0] exp,
                              input string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s (got %0h, expected %0h)", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // Reset is held low for five wclk cycles
    task automatic reset_task();
        @(negedge wclk);
        rst_n = 1'b0;
        repeat (5) @(negedge wclk);
        rst_n = 1'b1;
    endtask

    // One four-phase push, the entry joins the scoreboard at once
    task automatic push_task(input aw_queue_pkg::aw_entry_t entry);
        sb_q.push_back(entry);
        @(negedge wclk);
        push_entry = entry;
        push_req   = 1'b1;
        @(negedge wclk);
        while (!push_ack) @(negedge wclk);
        push_req = 1'b0;
        @(negedge wclk);
        while (push_ack) @(negedge wclk);
    endtask

    // One four-phase pop, compared with the oldest scoreboard entry
    task automatic pop_task();
        aw_queue_pkg::aw_entry_t got;
        aw_queue_pkg::aw_entry_t exp;
        @(negedge rclk);
        pop_req = 1'b1;
        @(negedge rclk);
        while (!pop_ack) @(negedge rclk);
        got = pop_entry;
        if (sb_q.size() == 0) begin
            $display("The queue returned an entry while the scoreboard was empty");
            $display("Done: errors found");
            $fatal(1, "Unexpected pop data");
        end else begin
            exp = sb_q.pop_front();
            check_task(got.qid, exp.qid, "pop_entry.qid");
            check_task(got.data, exp.data, "pop_entry.data");
            pop_req = 1'b0;
            @(negedge rclk);
            while (pop_ack) @(negedge rclk);
        end
    endtask

    // A pop on an empty queue stays unanswered until a push arrives
    task automatic pop_waits_for_push();
        aw_queue_pkg::aw_entry_t entry;
        entry = random_entry();
        fork
            pop_task();
            begin
                repeat (20) begin
                    @(negedge rclk);
                    check_task(pop_ack, 0, "pop_ack on an empty queue");
                end
                push_task(entry);
            end
        join
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------

    task automatic single_entry_test();
        check_task(push_ack, 0, "push_ack after reset");
        check_task(pop_ack, 0, "pop_ack after reset");
        @(negedge rclk);
        check_task(aw_queue_top_inst.rdata, 0, "register file read output after reset");
        push_task(random_entry());
        pop_task();
    endtask

    task automatic full_queue_test();
        repeat (16) push_task(random_entry());
        // The 17th request has to wait until a slot is freed
        fork
            push_task(random_entry());
            begin
                repeat (50) begin
                    @(negedge wclk);
                    check_task(push_ack, 0, "push_ack on a full queue");
                end
                pop_task();
            end
        join
        repeat (16) pop_task();
    endtask

    task automatic interleaved_test();
        int unsigned pushed;
        int unsigned popped;
        logic [63:0] pick;
        pushed = 0;
        popped = 0;
        while (popped < 40) begin
            pick = take_bits(1);
            if (pushed < 40 && (sb_q.size() == 0 || (pick[0] && sb_q.size() < 16))) begin
                push_task(random_entry());
                pushed++;
            end else begin
                pop_task();
                popped++;
            end
        end
    endtask

    task automatic reset_mid_traffic_test();
        repeat (5) push_task(random_entry());
        repeat (2) pop_task();
        // The three entries left behind are dropped by the reset
        reset_task();
        sb_q.delete();
        check_task(push_ack, 0, "push_ack after the second reset");
        check_task(pop_ack, 0, "pop_ack after the second reset");
        pop_waits_for_push();
        repeat (3) push_task(random_entry());
        repeat (3) pop_task();
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        rst_n      = 1'b0;
        push_req   = 1'b0;
        push_entry = '0;
        pop_req    = 1'b0;
        lfsr_q     = 32'h6dbe;

        reset_task();
        single_entry_test();
        pop_waits_for_push();
        full_queue_test();
        interleaved_test();
        reset_mid_traffic_test();

        repeat (5) @(negedge wclk);
        if (aw_queue_top_inst.aw_queue_assert_inst.fail_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("%0d handshake assertions failed",
                     aw_queue_top_inst.aw_queue_assert_inst.fail_count);
            $display("Done: errors found");
            $fatal(1, "Assertion failures");
        end
    end

endmodule

// ==== aw_queue.f ====
hdl/aw_queue_pkg.sv
hdl/mem_reset_sync.sv
hdl/mem_rf_16x39.sv
hdl/aw_push_ctl.sv
hdl/aw_pop_ctl.sv
hdl/aw_queue_top.sv
tb/aw_queue_assert.sv
tb/aw_queue_tb.sv

// ==== Makefile ====
# Verilator build and run for the queue testbench

TOP = aw_queue_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f aw_queue.f -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Done: no errors" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
